/* hdl/tpu_ctrl_types_pkg.sv */
package tpu_ctrl_types_pkg;

    // ====================
    // host command widths
    // ====================

    // these are fixed by the 64-bit host command format
    // and do not scale with the array width

    // scratchpad address, same width for all four operand regions
    typedef logic [9:0] addr_t;

    // length fields of the command word
    typedef logic [7:0] len_t;

    // raw command word as it arrives from the host
    typedef logic [63:0] cmd_word_t;

    // field sizes, handy for layout checks
    localparam int addr_bits = $bits(addr_t);
    localparam int len_bits  = $bits(len_t);
    localparam int cmd_bits  = $bits(cmd_word_t);

    // four addresses and three lengths fill the word exactly
    localparam int cmd_used_bits = 4 * addr_bits + 3 * len_bits;

endpackage

/* hdl/tpu_ctrl_cmd_pkg.sv */
package tpu_ctrl_cmd_pkg;

    // ====================
    // command layout
    // ====================

    // addr_c is reserved, len_m is carried but unused
    typedef struct packed {
        tpu_ctrl_types_pkg::addr_t addr_d;
        tpu_ctrl_types_pkg::addr_t addr_c;
        tpu_ctrl_types_pkg::addr_t addr_b;
        tpu_ctrl_types_pkg::addr_t addr_a;
        tpu_ctrl_types_pkg::len_t  len_n;
        tpu_ctrl_types_pkg::len_t  len_k;
        tpu_ctrl_types_pkg::len_t  len_m;
    } command_t;

    // ====================
    // stage hand-offs
    // ====================

    // scheduler to activation stage
    typedef struct packed {
        tpu_ctrl_types_pkg::addr_t addr_a;
        tpu_ctrl_types_pkg::addr_t addr_d;
    } act_task_t;

    // weight memory read port
    typedef struct packed {
        logic                      rd_en;
        tpu_ctrl_types_pkg::addr_t rd_addr;
    } weight_rd_t;

    // activation read port plus core strobes
    typedef struct packed {
        logic                      rd_en;
        tpu_ctrl_types_pkg::addr_t rd_addr;
        logic                      valid;
        logic                      switch;
        logic                      psum_valid;
    } act_ctrl_t;

    typedef enum logic [1:0] {
        idle,
        load,
        gap
    } sched_state_t;

endpackage

/* hdl/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  tpu_ctrl_types_pkg::cmd_word_t cmd_data,
    input  logic                          pop,
    output logic                          cmd_ready,
    output tpu_ctrl_cmd_pkg::command_t    head,
    output logic                          empty
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    tpu_ctrl_types_pkg::cmd_word_t mem [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             do_pop;

    assign cmd_ready = (count != cnt_w'(fifo_depth));
    assign empty     = (count == '0);
    assign push      = cmd_valid && cmd_ready;
    assign do_pop    = pop && !empty;
    assign head      = tpu_ctrl_cmd_pkg::command_t'(mem[rd_ptr]);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_data;
        end
    end

    // pointers wrap at fifo_depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/weight_scheduler.sv */
`timescale 1ns/1ps

module weight_scheduler #(
    parameter int array_width    = 16,
    parameter int wb_queue_depth = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  tpu_ctrl_cmd_pkg::command_t       head,
    input  logic                             empty,
    input  logic                             act_active,
    input  logic                             wb_active,
    input  logic                             credit_return,
    output logic                             pop,
    output logic                             act_start,
    output tpu_ctrl_cmd_pkg::act_task_t      act_task,
    output tpu_ctrl_cmd_pkg::weight_rd_t     weight_rd,
    output logic                             weight_accept,
    output logic [$clog2(array_width)-1:0]   weight_index,
    output logic                             busy,
    output logic [array_width-1:0]           row_mask,
    output logic [array_width-1:0]           col_mask
);

    localparam int idx_w    = $clog2(array_width);
    localparam int credit_w = $clog2(wb_queue_depth + 1);

    tpu_ctrl_cmd_pkg::sched_state_t state;

    logic [idx_w-1:0]          beat;
    logic [credit_w-1:0]       credits;
    logic                      start;
    tpu_ctrl_types_pkg::addr_t rd_addr;
    tpu_ctrl_types_pkg::len_t  len_k;
    tpu_ctrl_types_pkg::len_t  len_n;

    // a start needs a queued command and a free writeback slot
    assign start = !empty && (credits != '0) && (state != tpu_ctrl_cmd_pkg::load);
    assign pop   = start;

    // hand-off happens in the gap cycle after each weight burst
    assign act_start = (state == tpu_ctrl_cmd_pkg::gap);

    assign weight_rd.rd_en   = (state == tpu_ctrl_cmd_pkg::load);
    assign weight_rd.rd_addr = rd_addr;

    // ====================
    // control FSM
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tpu_ctrl_cmd_pkg::idle;
            beat  <= '0;
        end else begin
            case (state)
                tpu_ctrl_cmd_pkg::idle: begin
                    if (start) begin
                        state <= tpu_ctrl_cmd_pkg::load;
                    end
                    beat <= '0;
                end
                tpu_ctrl_cmd_pkg::load: begin
                    if (beat == idx_w'(array_width - 1)) begin
                        state <= tpu_ctrl_cmd_pkg::gap;
                        beat  <= '0;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                tpu_ctrl_cmd_pkg::gap: begin
                    // back-to-back commands skip idle
                    state <= start ? tpu_ctrl_cmd_pkg::load : tpu_ctrl_cmd_pkg::idle;
                    beat  <= '0;
                end
                default: begin
                    state <= tpu_ctrl_cmd_pkg::idle;
                    beat  <= '0;
                end
            endcase
        end
    end

    // weights are read top row first
    always_ff @(posedge clk) begin
        if (start) begin
            rd_addr         <= head.addr_b + tpu_ctrl_types_pkg::addr_t'(array_width - 1);
            act_task.addr_a <= head.addr_a;
            act_task.addr_d <= head.addr_d;
        end else if (weight_rd.rd_en) begin
            rd_addr <= rd_addr - 1'b1;
        end
    end

    // lengths of the most recently started command
    always_ff @(posedge clk) begin
        if (rst) begin
            len_k <= '0;
            len_n <= '0;
        end else if (start) begin
            len_k <= head.len_k;
            len_n <= head.len_n;
        end
    end

    // ====================
    // credits
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_w'(wb_queue_depth);
        end else begin
            case ({start, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // core side strobes trail the read by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            weight_accept <= 1'b0;
            weight_index  <= '0;
        end else begin
            weight_accept <= weight_rd.rd_en;
            if (weight_rd.rd_en) begin
                weight_index <= idx_w'(array_width - 1) - beat;
            end
        end
    end

    assign busy = !empty || (state != tpu_ctrl_cmd_pkg::idle) || act_active || wb_active
                  || (credits != credit_w'(wb_queue_depth));

    // thermometer masks, lengths past the array width saturate
    always_comb begin
        row_mask = '0;
        col_mask = '0;
        for (int i = 0; i < array_width; i++) begin
            if (busy && (i < int'(len_k))) begin
                row_mask[i] = 1'b1;
            end
            if (busy && (i < int'(len_n))) begin
                col_mask[i] = 1'b1;
            end
        end
    end

endmodule

/* hdl/activation_sequencer.sv */
`timescale 1ns/1ps

module activation_sequencer #(
    parameter int array_width = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        act_start,
    input  tpu_ctrl_cmd_pkg::act_task_t act_task,
    output tpu_ctrl_cmd_pkg::act_ctrl_t act_ctrl,
    output logic                        act_active,
    output logic                        wb_push,
    output tpu_ctrl_types_pkg::addr_t   wb_addr
);

    localparam int idx_w = $clog2(array_width);

    logic                      active;
    logic [idx_w-1:0]          beat;
    logic                      rd_en_q;
    logic                      first_beat;
    tpu_ctrl_types_pkg::addr_t rd_addr;
    tpu_ctrl_types_pkg::addr_t addr_d;

    assign first_beat = active && (beat == '0);

    // ====================
    // burst control
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            beat    <= '0;
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= active;
            if (act_start) begin
                active <= 1'b1;
                beat   <= '0;
            end else if (active) begin
                if (beat == idx_w'(array_width - 1)) begin
                    active <= 1'b0;
                    beat   <= '0;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    // input rows read in ascending order
    always_ff @(posedge clk) begin
        if (act_start) begin
            rd_addr <= act_task.addr_a;
            addr_d  <= act_task.addr_d;
        end else if (active) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign act_ctrl.rd_en   = active;
    assign act_ctrl.rd_addr = rd_addr;

    // weights swap into the array as the new burst begins
    assign act_ctrl.switch = first_beat;

    // data and partial sums arrive one cycle after the read
    assign act_ctrl.valid      = rd_en_q;
    assign act_ctrl.psum_valid = rd_en_q;

    // destination goes to writeback as the burst starts
    assign wb_push = first_beat;
    assign wb_addr = addr_d;

    assign act_active = active || rd_en_q;

endmodule

/* hdl/writeback_tracker.sv */
`timescale 1ns/1ps

module writeback_tracker #(
    parameter int array_width    = 16,
    parameter int wb_queue_depth = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_push,
    input  tpu_ctrl_types_pkg::addr_t wb_addr,
    input  logic                      core_writeback_valid,
    output tpu_ctrl_types_pkg::addr_t wr_addr_d,
    output logic                      wb_active,
    output logic                      done_irq,
    output logic                      credit_return
);

    localparam int qp_w  = (wb_queue_depth > 1) ? $clog2(wb_queue_depth) : 1;
    localparam int qc_w  = $clog2(wb_queue_depth + 1);
    localparam int row_w = $clog2(array_width);

    tpu_ctrl_types_pkg::addr_t queue_mem [wb_queue_depth];

    logic [qp_w-1:0]  wr_ptr;
    logic [qp_w-1:0]  rd_ptr;
    logic [qc_w-1:0]  count;
    logic             active;
    logic [row_w-1:0] rows;
    logic             load_task;
    logic             row_in;
    logic             done;

    assign load_task = !active && (count != '0);
    assign row_in    = active && core_writeback_valid;

    // ====================
    // destination queue
    // ====================
    always_ff @(posedge clk) begin
        if (wb_push) begin
            queue_mem[wr_ptr] <= wb_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wb_push) begin
                wr_ptr <= (wr_ptr == qp_w'(wb_queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (load_task) begin
                rd_ptr <= (rd_ptr == qp_w'(wb_queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wb_push, load_task})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ====================
    // row counting
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            rows   <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load_task) begin
                active <= 1'b1;
                rows   <= '0;
            end else if (row_in) begin
                rows <= rows + 1'b1;
                // last result row of this task
                if (rows == row_w'(array_width - 1)) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_task) begin
            wr_addr_d <= queue_mem[rd_ptr];
        end else if (row_in) begin
            wr_addr_d <= wr_addr_d + 1'b1;
        end
    end

    // one freed slot per finished task
    assign done_irq      = done;
    assign credit_return = done;
    assign wb_active     = active || (count != '0);

endmodule

/* hdl/tpu_ctrl.sv */
`timescale 1ns/1ps

module tpu_ctrl #(
    parameter int array_width    = 16,
    parameter int fifo_depth     = 4,
    parameter int wb_queue_depth = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_valid,
    input  tpu_ctrl_types_pkg::cmd_word_t  cmd_data,
    input  logic                           core_writeback_valid,
    output logic                           cmd_ready,
    output logic                           busy,
    output logic                           done_irq,
    output tpu_ctrl_cmd_pkg::weight_rd_t   weight_rd,
    output logic                           weight_accept,
    output logic [$clog2(array_width)-1:0] weight_index,
    output tpu_ctrl_cmd_pkg::act_ctrl_t    act_ctrl,
    output tpu_ctrl_types_pkg::addr_t      wr_addr_d,
    output logic [array_width-1:0]         row_mask,
    output logic [array_width-1:0]         col_mask
);

    tpu_ctrl_cmd_pkg::command_t  fifo_head;
    logic                        fifo_empty;
    logic                        pop;
    logic                        act_start;
    tpu_ctrl_cmd_pkg::act_task_t act_task;
    logic                        act_active;
    logic                        wb_push;
    tpu_ctrl_types_pkg::addr_t   wb_addr;
    logic                        wb_active;
    logic                        credit_return;

    cmd_fifo #(
        .fifo_depth (fifo_depth)
    ) i_cmd_fifo (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .pop       (pop),
        .cmd_ready (cmd_ready),
        .head      (fifo_head),
        .empty     (fifo_empty)
    );

    weight_scheduler #(
        .array_width    (array_width),
        .wb_queue_depth (wb_queue_depth)
    ) i_weight_scheduler (
        .clk           (clk),
        .rst           (rst),
        .head          (fifo_head),
        .empty         (fifo_empty),
        .act_active    (act_active),
        .wb_active     (wb_active),
        .credit_return (credit_return),
        .pop           (pop),
        .act_start     (act_start),
        .act_task      (act_task),
        .weight_rd     (weight_rd),
        .weight_accept (weight_accept),
        .weight_index  (weight_index),
        .busy          (busy),
        .row_mask      (row_mask),
        .col_mask      (col_mask)
    );

    activation_sequencer #(
        .array_width (array_width)
    ) i_activation_sequencer (
        .clk        (clk),
        .rst        (rst),
        .act_start  (act_start),
        .act_task   (act_task),
        .act_ctrl   (act_ctrl),
        .act_active (act_active),
        .wb_push    (wb_push),
        .wb_addr    (wb_addr)
    );

    writeback_tracker #(
        .array_width    (array_width),
        .wb_queue_depth (wb_queue_depth)
    ) i_writeback_tracker (
        .clk                  (clk),
        .rst                  (rst),
        .wb_push              (wb_push),
        .wb_addr              (wb_addr),
        .core_writeback_valid (core_writeback_valid),
        .wr_addr_d            (wr_addr_d),
        .wb_active            (wb_active),
        .done_irq             (done_irq),
        .credit_return        (credit_return)
    );

endmodule

/* tests/tpu_ctrl_tb.sv */
`timescale 1ns/1ps

module tpu_ctrl_tb;

    localparam int array_width    = 16;
    localparam int fifo_depth     = 4;
    localparam int wb_queue_depth = 4;

    logic                          clk;
    logic                          rst;
    logic                          cmd_valid;
    tpu_ctrl_types_pkg::cmd_word_t cmd_data;
    logic                          core_writeback_valid;
    logic                          cmd_ready;
    logic                          busy;
    logic                          done_irq;
    tpu_ctrl_cmd_pkg::weight_rd_t  weight_rd;
    logic                          weight_accept;
    logic [$clog2(array_width)-1:0] weight_index;
    tpu_ctrl_cmd_pkg::act_ctrl_t   act_ctrl;
    tpu_ctrl_types_pkg::addr_t     wr_addr_d;
    logic [array_width-1:0]        row_mask;
    logic [array_width-1:0]        col_mask;

    // reference record of accepted commands in order
    tpu_ctrl_cmd_pkg::command_t cmds[$];

    int  w_beat;
    int  w_started;
    int  w_done;
    int  exp_index;
    int  a_beat;
    int  a_started;
    int  ld_idx;
    int  done_count;
    int  wb_pending;
    int  wb_rows;
    bit  prev_w_rd_en;
    bit  prev_a_rd_en;
    bit  wb_busy_model;
    bit  exp_done;
    bit  done_seen;
    bit  push_seen;
    bit  offer_taken;
    int  fail_count;
    tpu_ctrl_types_pkg::addr_t cur_addr_d;

    tpu_ctrl i_dut (
        .clk                  (clk),
        .rst                  (rst),
        .cmd_valid            (cmd_valid),
        .cmd_data             (cmd_data),
        .core_writeback_valid (core_writeback_valid),
        .cmd_ready            (cmd_ready),
        .busy                 (busy),
        .done_irq             (done_irq),
        .weight_rd            (weight_rd),
        .weight_accept        (weight_accept),
        .weight_index         (weight_index),
        .act_ctrl             (act_ctrl),
        .wr_addr_d            (wr_addr_d),
        .row_mask             (row_mask),
        .col_mask             (col_mask)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string line);
        fail_count++;
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("Mismatch at %0t: %s", $time, msg));
    endtask

    function automatic logic [array_width-1:0] thermometer(input int len);
        logic [array_width-1:0] ones;
        ones = '1;
        if (len >= array_width) begin
            return ones;
        end
        return ones >> (array_width - len);
    endfunction

    function automatic tpu_ctrl_types_pkg::cmd_word_t random_command();
        tpu_ctrl_cmd_pkg::command_t cmd;
        cmd.addr_d = tpu_ctrl_types_pkg::addr_t'($urandom);
        cmd.addr_c = tpu_ctrl_types_pkg::addr_t'($urandom);
        cmd.addr_b = tpu_ctrl_types_pkg::addr_t'($urandom);
        cmd.addr_a = tpu_ctrl_types_pkg::addr_t'($urandom);
        // lengths straddle the array width so saturation gets exercised
        cmd.len_n  = tpu_ctrl_types_pkg::len_t'($urandom_range(0, array_width + 24));
        cmd.len_k  = tpu_ctrl_types_pkg::len_t'($urandom_range(0, array_width + 24));
        cmd.len_m  = tpu_ctrl_types_pkg::len_t'($urandom);
        return tpu_ctrl_types_pkg::cmd_word_t'(cmd);
    endfunction

    // ====================
    // output monitors
    // ====================

    task automatic track_weights();
        tpu_ctrl_types_pkg::addr_t exp_addr;
        assert (weight_accept == prev_w_rd_en)
            else report_mismatch("weight_accept is not rd_en delayed by one cycle");
        if (weight_accept) begin
            assert (weight_index == exp_index)
                else report_mismatch($sformatf("weight_index %0d, expected %0d",
                                               weight_index, exp_index));
        end
        if (weight_rd.rd_en) begin
            if (w_beat == 0) begin
                assert (w_started < cmds.size())
                    else report_mismatch("weight burst without an accepted command");
                w_started++;
            end
            // top row first
            exp_addr = cmds[w_started-1].addr_b
                       + tpu_ctrl_types_pkg::addr_t'(array_width - 1 - w_beat);
            assert (weight_rd.rd_addr == exp_addr)
                else report_mismatch($sformatf("weight rd_addr %0h, expected %0h",
                                               weight_rd.rd_addr, exp_addr));
            exp_index = array_width - 1 - w_beat;
            w_beat++;
            assert (w_beat <= array_width)
                else report_mismatch("weight burst longer than W cycles");
        end else if (w_beat != 0) begin
            assert (w_beat == array_width)
                else report_mismatch("weight burst shorter than W cycles");
            w_beat = 0;
            w_done++;
        end
        prev_w_rd_en = weight_rd.rd_en;
    endtask

    task automatic track_activations();
        tpu_ctrl_types_pkg::addr_t exp_addr;
        push_seen = 1'b0;
        assert (act_ctrl.valid == prev_a_rd_en)
            else report_mismatch("activation valid is not rd_en delayed by one cycle");
        assert (act_ctrl.psum_valid == prev_a_rd_en)
            else report_mismatch("psum_valid is not rd_en delayed by one cycle");
        if (act_ctrl.rd_en) begin
            if (a_beat == 0) begin
                assert (a_started < w_done)
                    else report_mismatch("activation burst began before its weight burst ended");
                a_started++;
                push_seen = 1'b1;
            end
            assert (act_ctrl.switch == (a_beat == 0))
                else report_mismatch("switch not limited to the first burst cycle");
            exp_addr = cmds[a_started-1].addr_a + tpu_ctrl_types_pkg::addr_t'(a_beat);
            assert (act_ctrl.rd_addr == exp_addr)
                else report_mismatch($sformatf("activation rd_addr %0h, expected %0h",
                                               act_ctrl.rd_addr, exp_addr));
            a_beat++;
            assert (a_beat <= array_width)
                else report_mismatch("activation burst longer than W cycles");
        end else begin
            assert (!act_ctrl.switch) else report_mismatch("switch high outside a burst");
            if (a_beat != 0) begin
                assert (a_beat == array_width)
                    else report_mismatch("activation burst shorter than W cycles");
                a_beat = 0;
            end
        end
        prev_a_rd_en = act_ctrl.rd_en;
    endtask

    // tracker loads one cycle after its queue turns non-empty while idle
    task automatic model_writeback();
        tpu_ctrl_types_pkg::addr_t exp_addr;
        bit finish_now;
        bit load_now;
        finish_now = 1'b0;
        assert (done_irq == exp_done)
            else report_mismatch(exp_done ? "done_irq missing after W rows"
                                          : "unexpected done_irq");
        done_seen = exp_done;
        if (done_seen) begin
            done_count++;
        end
        if (wb_busy_model) begin
            exp_addr = cur_addr_d + tpu_ctrl_types_pkg::addr_t'(wb_rows);
            assert (wr_addr_d == exp_addr)
                else report_mismatch($sformatf("wr_addr_d %0h, expected %0h",
                                               wr_addr_d, exp_addr));
            if (core_writeback_valid) begin
                wb_rows++;
                finish_now = (wb_rows == array_width);
            end
        end
        load_now = !wb_busy_model && (wb_pending > 0);
        exp_done = finish_now;
        if (finish_now) begin
            wb_busy_model = 1'b0;
        end
        if (load_now) begin
            cur_addr_d    = cmds[ld_idx].addr_d;
            ld_idx++;
            wb_busy_model = 1'b1;
            wb_rows       = 0;
            wb_pending--;
        end
        if (push_seen) begin
            wb_pending++;
        end
    endtask

    task automatic compare_masks_and_flow();
        logic [array_width-1:0] exp_row;
        logic [array_width-1:0] exp_col;
        bit                     exp_busy;
        int                     occupancy;
        // busy stays high through the cycle of the last done_irq
        exp_busy = (cmds.size() > done_count) || done_seen;
        assert (busy == exp_busy)
            else report_mismatch($sformatf("busy %0b, expected %0b", busy, exp_busy));
        exp_row = '0;
        exp_col = '0;
        if (exp_busy && (w_started > 0)) begin
            exp_row = thermometer(int'(cmds[w_started-1].len_k));
            exp_col = thermometer(int'(cmds[w_started-1].len_n));
        end
        assert (row_mask == exp_row)
            else report_mismatch($sformatf("row_mask %h, expected %h", row_mask, exp_row));
        assert (col_mask == exp_col)
            else report_mismatch($sformatf("col_mask %h, expected %h", col_mask, exp_col));
        assert (w_started - done_count <= wb_queue_depth)
            else report_mismatch("more weight bursts started than writeback credits allow");
        occupancy = cmds.size() - w_started;
        assert (cmd_ready == (occupancy < fifo_depth))
            else report_mismatch($sformatf("cmd_ready %0b with %0d queued", cmd_ready, occupancy));
    endtask

    task automatic record_accepted();
        if (cmd_valid && cmd_ready) begin
            cmds.push_back(tpu_ctrl_cmd_pkg::command_t'(cmd_data));
            offer_taken = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            track_weights();
            track_activations();
            model_writeback();
            compare_masks_and_flow();
            record_accepted();
        end
    end

    // ====================
    // stimulus
    // ====================

    // an offer is held until the queue takes it
    task automatic drive_cycle(input int offer_pct, input int valid_pct);
        @(posedge clk);
        #2;
        if (!cmd_valid || offer_taken) begin
            offer_taken = 1'b0;
            cmd_valid   = ($urandom_range(0, 99) < offer_pct);
            if (cmd_valid) begin
                cmd_data = random_command();
            end
        end
        core_writeback_valid = ($urandom_range(0, 99) < valid_pct);
    endtask

    task automatic drain_commands(input int valid_pct);
        int i;
        for (i = 0; i < 6000; i++) begin
            drive_cycle(0, valid_pct);
            if (!cmd_valid && (done_count == cmds.size())) begin
                break;
            end
        end
        if (i == 6000) begin
            abort_run("timed out waiting for all commands to complete");
        end
    endtask

    task automatic stall_core();
        int i;
        for (i = 0; i < 200; i++) begin
            drive_cycle(100, 0);
            if (!cmd_ready) begin
                break;
            end
        end
        if (i == 200) begin
            abort_run("timed out waiting for the command queue to fill");
        end
        // the scheduler keeps pulling commands until the credits run out
        for (i = 0; i < 200; i++) begin
            drive_cycle(100, 0);
            if (!cmd_ready && (w_started - done_count == wb_queue_depth)) begin
                break;
            end
        end
        if (i == 200) begin
            abort_run("timed out waiting for the credited weight bursts to start");
        end
        // hold the stall past two more start slots
        repeat (2 * (array_width + 1)) drive_cycle(100, 0);
        assert (w_started - done_count == wb_queue_depth)
            else report_mismatch("stalled core did not hold exactly the credited bursts");
        assert (cmds.size() - done_count == fifo_depth + wb_queue_depth)
            else report_mismatch("accepted command count wrong under back-pressure");
    endtask

    task automatic wait_for_idle();
        int i;
        for (i = 0; i < 100; i++) begin
            drive_cycle(0, 50);
            if (!busy) begin
                break;
            end
        end
        if (i == 100) begin
            abort_run("timed out waiting for busy to fall");
        end
        @(negedge clk);
        assert ((row_mask == '0) && (col_mask == '0))
            else report_mismatch("masks not cleared when idle");
    endtask

    task automatic expect_reset_state();
        assert (!weight_rd.rd_en && !weight_accept && !done_irq && !busy)
            else report_mismatch("scheduler outputs active after reset");
        assert (!act_ctrl.rd_en && !act_ctrl.valid && !act_ctrl.switch && !act_ctrl.psum_valid)
            else report_mismatch("activation outputs active after reset");
        assert ((row_mask == '0) && (col_mask == '0) && cmd_ready)
            else report_mismatch("masks or cmd_ready wrong after reset");
    endtask

    initial begin
        void'($urandom(14752));
        rst                  = 1'b1;
        cmd_valid            = 1'b0;
        cmd_data             = '0;
        core_writeback_valid = 1'b0;
        fail_count           = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        expect_reset_state();

        repeat (900) drive_cycle(40, 65);
        drain_commands(70);

        stall_core();
        drain_commands(60);
        wait_for_idle();

        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tpu_ctrl.f */
hdl/tpu_ctrl_types_pkg.sv
hdl/tpu_ctrl_cmd_pkg.sv
hdl/cmd_fifo.sv
hdl/weight_scheduler.sv
hdl/activation_sequencer.sv
hdl/writeback_tracker.sv
hdl/tpu_ctrl.sv
tests/tpu_ctrl_tb.sv

/* Bender.yml */
package:
  name: tpu_ctrl

sources:
  # packages first, then the stages, then the top level
  - files:
      - hdl/tpu_ctrl_types_pkg.sv
      - hdl/tpu_ctrl_cmd_pkg.sv
      - hdl/cmd_fifo.sv
      - hdl/weight_scheduler.sv
      - hdl/activation_sequencer.sv
      - hdl/writeback_tracker.sv
      - hdl/tpu_ctrl.sv
  - target: test
    files:
      - tests/tpu_ctrl_tb.sv
